// File: rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 6;
    localparam int FUNCT_W   = 6;
    localparam int IMM_W     = 16;
    localparam int TARGET_W  = 26;

    // primary opcodes, bits 31:26
    localparam logic [OPCODE_W-1:0] OP_SPECIAL = 6'b000000;  // r-type, decoded by funct
    localparam logic [OPCODE_W-1:0] OP_REGIMM  = 6'b000001;  // branches selected by rt
    localparam logic [OPCODE_W-1:0] OP_J       = 6'b000010;
    localparam logic [OPCODE_W-1:0] OP_JAL     = 6'b000011;
    localparam logic [OPCODE_W-1:0] OP_BEQ     = 6'b000100;
    localparam logic [OPCODE_W-1:0] OP_BNE     = 6'b000101;
    localparam logic [OPCODE_W-1:0] OP_BLEZ    = 6'b000110;
    localparam logic [OPCODE_W-1:0] OP_BGTZ    = 6'b000111;
    localparam logic [OPCODE_W-1:0] OP_ADDI    = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_ADDIU   = 6'b001001;
    localparam logic [OPCODE_W-1:0] OP_SLTI    = 6'b001010;
    localparam logic [OPCODE_W-1:0] OP_SLTIU   = 6'b001011;
    localparam logic [OPCODE_W-1:0] OP_ANDI    = 6'b001100;
    localparam logic [OPCODE_W-1:0] OP_ORI     = 6'b001101;
    localparam logic [OPCODE_W-1:0] OP_XORI    = 6'b001110;
    localparam logic [OPCODE_W-1:0] OP_LUI     = 6'b001111;
    localparam logic [OPCODE_W-1:0] OP_LB      = 6'b100000;
    localparam logic [OPCODE_W-1:0] OP_LH      = 6'b100001;
    localparam logic [OPCODE_W-1:0] OP_LWL     = 6'b100010;
    localparam logic [OPCODE_W-1:0] OP_LW      = 6'b100011;
    localparam logic [OPCODE_W-1:0] OP_LBU     = 6'b100100;
    localparam logic [OPCODE_W-1:0] OP_LHU     = 6'b100101;
    localparam logic [OPCODE_W-1:0] OP_LWR     = 6'b100110;
    localparam logic [OPCODE_W-1:0] OP_SB      = 6'b101000;
    localparam logic [OPCODE_W-1:0] OP_SH      = 6'b101001;
    localparam logic [OPCODE_W-1:0] OP_SW      = 6'b101011;

    // function field of OP_SPECIAL, bits 5:0
    localparam logic [FUNCT_W-1:0] FN_SLL   = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRL   = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN_SRA   = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_SLLV  = 6'b000100;
    localparam logic [FUNCT_W-1:0] FN_SRLV  = 6'b000110;
    localparam logic [FUNCT_W-1:0] FN_SRAV  = 6'b000111;
    localparam logic [FUNCT_W-1:0] FN_JR    = 6'b001000;
    localparam logic [FUNCT_W-1:0] FN_JALR  = 6'b001001;
    localparam logic [FUNCT_W-1:0] FN_MFHI  = 6'b010000;
    localparam logic [FUNCT_W-1:0] FN_MTHI  = 6'b010001;
    localparam logic [FUNCT_W-1:0] FN_MFLO  = 6'b010010;
    localparam logic [FUNCT_W-1:0] FN_MTLO  = 6'b010011;
    localparam logic [FUNCT_W-1:0] FN_MULT  = 6'b011000;
    localparam logic [FUNCT_W-1:0] FN_MULTU = 6'b011001;
    localparam logic [FUNCT_W-1:0] FN_DIV   = 6'b011010;
    localparam logic [FUNCT_W-1:0] FN_DIVU  = 6'b011011;
    localparam logic [FUNCT_W-1:0] FN_ADD   = 6'b100000;
    localparam logic [FUNCT_W-1:0] FN_ADDU  = 6'b100001;
    localparam logic [FUNCT_W-1:0] FN_SUBU  = 6'b100011;
    localparam logic [FUNCT_W-1:0] FN_AND   = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR    = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_XOR   = 6'b100110;
    localparam logic [FUNCT_W-1:0] FN_SLT   = 6'b101010;
    localparam logic [FUNCT_W-1:0] FN_SLTU  = 6'b101011;

    // rt field of OP_REGIMM
    localparam logic [REG_IDX_W-1:0] RT_BLTZ   = 5'b00000;
    localparam logic [REG_IDX_W-1:0] RT_BGEZ   = 5'b00001;
    localparam logic [REG_IDX_W-1:0] RT_BLTZAL = 5'b10000;
    localparam logic [REG_IDX_W-1:0] RT_BGEZAL = 5'b10001;

    // one instruction word seen through its three encodings
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]  opcode;
            logic [REG_IDX_W-1:0] rs;
            logic [REG_IDX_W-1:0] rt;
            logic [REG_IDX_W-1:0] rd;
            logic [REG_IDX_W-1:0] shamt;
            logic [FUNCT_W-1:0]   funct;
        } r;
        struct packed {
            logic [OPCODE_W-1:0]  opcode;
            logic [REG_IDX_W-1:0] rs;
            logic [REG_IDX_W-1:0] rt;
            logic [IMM_W-1:0]     imm;
        } i;
        struct packed {
            logic [OPCODE_W-1:0]  opcode;
            logic [TARGET_W-1:0]  target;
        } j;
    } instr_word_u;

endpackage

// File: rtl/decode_pkg.sv
package decode_pkg;

    import mips_isa_pkg::*;

    // decoder operation codes, numbering follows the execute unit's table
    typedef enum logic [6:0] {
        INVALID = 7'd0,                    // unrecognised encoding
        // alu and multiply / divide
        ADD     = 7'd1,  ADDI,  ADDIU, ADDU,
        AND,    ANDI,    DIV,   DIVU,
        MFHI,   MFLO,    MTHI,  MTLO,
        MULT,   MULTU,   OR,    ORI,
        SLL,    SLLV,    SLT,   SLTI,
        SLTIU,  SLTU,    SRA,   SRAV,
        SRL,    SRLV,    SUBU,  XOR,
        XORI,
        // branches and jumps
        BEQ     = 7'd30, BGEZ,  BGEZAL, BGTZ,
        BLEZ,   BLTZ,    BLTZAL, BNE,
        J,      JAL,     JALR,  JR,
        // memory
        LB      = 7'd42, LBU,   LH,    LHU,
        LUI,    LW,      LWL,   LWR,
        SB,     SH,      SW
    } instr_code_t;

    // sll r0, r0, 0 decodes as a harmless nop
    localparam logic [WORD_W-1:0] BUBBLE_WORD = '0;

    localparam logic [REG_IDX_W-1:0] LINK_REG = 5'd31;  // $ra

endpackage

// File: rtl/decode_if.sv
interface decode_if
    import mips_isa_pkg::*;
    import decode_pkg::*;
();

    instr_word_u            word;    // raw slot word
    instr_code_t            code;
    logic [REG_IDX_W-1:0]   rs;
    logic [REG_IDX_W-1:0]   rt;
    logic [REG_IDX_W-1:0]   dest;    // write-back register
    logic [REG_IDX_W-1:0]   shamt;
    logic [WORD_W-1:0]      imm;     // already formatted for the alu
    logic [TARGET_W-1:0]    target;

    // field extraction side, sees the word and its code
    modport producer (
        input  word, code,
        output dest, shamt, imm, target
    );

    modport consumer (
        input word, code, rs, rt, dest, shamt, imm, target
    );

endinterface

// File: rtl/instr_classifier.sv
module instr_classifier
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input  instr_word_u i_word,
    output instr_code_t o_code
);

    always_comb begin
        o_code = INVALID;
        case (i_word.r.opcode)
            OP_SPECIAL: begin
                case (i_word.r.funct)
                    FN_ADD:   o_code = ADD;
                    FN_ADDU:  o_code = ADDU;
                    FN_AND:   o_code = AND;
                    FN_DIV:   o_code = DIV;
                    FN_DIVU:  o_code = DIVU;
                    FN_MFHI:  o_code = MFHI;
                    FN_MFLO:  o_code = MFLO;
                    FN_MTHI:  o_code = MTHI;
                    FN_MTLO:  o_code = MTLO;
                    FN_MULT:  o_code = MULT;
                    FN_MULTU: o_code = MULTU;
                    FN_OR:    o_code = OR;
                    FN_SLL:   o_code = SLL;      // also the bubble
                    FN_SLLV:  o_code = SLLV;
                    FN_SLT:   o_code = SLT;
                    FN_SLTU:  o_code = SLTU;
                    FN_SRA:   o_code = SRA;
                    FN_SRAV:  o_code = SRAV;
                    FN_SRL:   o_code = SRL;
                    FN_SRLV:  o_code = SRLV;
                    FN_SUBU:  o_code = SUBU;
                    FN_XOR:   o_code = XOR;
                    FN_JALR:  o_code = JALR;
                    FN_JR:    o_code = JR;
                    default:  o_code = INVALID;
                endcase
            end
            OP_REGIMM: begin
                // branch kind lives in the rt slot
                case (i_word.i.rt)
                    RT_BLTZ:   o_code = BLTZ;
                    RT_BGEZ:   o_code = BGEZ;
                    RT_BLTZAL: o_code = BLTZAL;
                    RT_BGEZAL: o_code = BGEZAL;
                    default:   o_code = INVALID;
                endcase
            end
            OP_J:     o_code = J;
            OP_JAL:   o_code = JAL;
            OP_BEQ:   o_code = BEQ;
            OP_BNE:   o_code = BNE;
            OP_BLEZ:  o_code = BLEZ;
            OP_BGTZ:  o_code = BGTZ;
            OP_ADDI:  o_code = ADDI;
            OP_ADDIU: o_code = ADDIU;
            OP_SLTI:  o_code = SLTI;
            OP_SLTIU: o_code = SLTIU;
            OP_ANDI:  o_code = ANDI;
            OP_ORI:   o_code = ORI;
            OP_XORI:  o_code = XORI;
            OP_LUI:   o_code = LUI;
            OP_LB:    o_code = LB;
            OP_LH:    o_code = LH;
            OP_LWL:   o_code = LWL;
            OP_LW:    o_code = LW;
            OP_LBU:   o_code = LBU;
            OP_LHU:   o_code = LHU;
            OP_LWR:   o_code = LWR;
            OP_SB:    o_code = SB;
            OP_SH:    o_code = SH;
            OP_SW:    o_code = SW;
            default:  o_code = INVALID;
        endcase
    end

endmodule

// File: rtl/field_extractor.sv
module field_extractor
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    decode_if.producer fields
);

    localparam int EXT_W = WORD_W - IMM_W;

    logic is_r_type;
    logic is_j_type;

    assign is_r_type = (fields.word.r.opcode == OP_SPECIAL);
    assign is_j_type = (fields.word.j.opcode == OP_J) || (fields.word.j.opcode == OP_JAL);

    always_comb begin
        fields.dest   = '0;
        fields.shamt  = '0;
        fields.imm    = '0;
        fields.target = '0;

        if (is_r_type) begin
            fields.dest  = fields.word.r.rd;
            fields.shamt = fields.word.r.shamt;
        end else if (is_j_type) begin
            fields.target = fields.word.j.target;
            if (fields.code == JAL) begin
                fields.dest = LINK_REG;
            end
        end else begin
            // i-type, rt is the destination except for the linking branches
            if (fields.code == BGEZAL || fields.code == BLTZAL) begin
                fields.dest = LINK_REG;
            end else begin
                fields.dest = fields.word.i.rt;
            end

            case (fields.code)
                ANDI, ORI, XORI: begin
                    fields.imm = {{EXT_W{1'b0}}, fields.word.i.imm};  // logical ops
                end
                LUI: begin
                    fields.imm = {fields.word.i.imm, {EXT_W{1'b0}}};
                end
                default: begin
                    fields.imm = {{EXT_W{fields.word.i.imm[IMM_W-1]}}, fields.word.i.imm};
                end
            endcase
        end
    end

endmodule

// File: rtl/slot_control.sv
module slot_control
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,
    input  logic [WORD_W-1:0] i_instr,
    input  logic              i_instr_valid,
    input  logic              i_mem_wait,
    input  instr_code_t       i_code_1,
    output instr_word_u       o_word_1,
    output instr_word_u       o_word_2,
    output logic              o_stall
);

    logic is_mem_1;

    // loads and stores touch data memory, lui does not
    assign is_mem_1 = i_code_1 inside {LB, LBU, LH, LHU, LW, LWL, LWR, SB, SH, SW};

    assign o_stall = i_mem_wait && is_mem_1;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_word_1 <= BUBBLE_WORD;
            o_word_2 <= BUBBLE_WORD;
        end else if (o_stall) begin
            o_word_2 <= BUBBLE_WORD;  // slot 1 holds, fetch re-presents
        end else begin
            o_word_2 <= o_word_1;
            o_word_1 <= i_instr_valid ? i_instr : BUBBLE_WORD;
        end
    end

    // a stall freezes slot 1 and pushes a bubble into slot 2
    a_stall_holds: assert property (
        @(posedge clk) disable iff (i_reset)
        o_stall |=> (o_word_2 == BUBBLE_WORD) && (o_word_1 == $past(o_word_1))
    ) else $error("slot_control: stall did not hold slot 1 or bubble slot 2");

endmodule

// File: rtl/writeback_control.sv
module writeback_control
    import decode_pkg::*;
(
    decode_if.consumer slot,
    output logic       o_reg_write
);

    logic writes_reg;

    always_comb begin
        case (slot.code)
            // r-type with a gpr result
            ADD, ADDU, AND, OR, XOR, SUBU, SLT, SLTU,
            SLL, SLLV, SRA, SRAV, SRL, SRLV,
            MFHI, MFLO, JALR: begin
                writes_reg = 1'b1;
            end
            // immediates, loads and lui
            ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI,
            LB, LBU, LH, LHU, LW, LWL, LWR: begin
                writes_reg = 1'b1;
            end
            JAL, BGEZAL, BLTZAL: begin
                writes_reg = 1'b1;               // link into $ra
            end
            default: begin
                writes_reg = 1'b0;  // stores, plain branches, hi/lo writes, invalid
            end
        endcase
    end

    // r0 is hardwired, never worth a write
    assign o_reg_write = writes_reg && (slot.dest != '0);

endmodule

// File: rtl/instr_decoder.sv
module instr_decoder
    import mips_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic [WORD_W-1:0]    i_instr,
    input  logic                 i_instr_valid,
    input  logic                 i_mem_wait,

    // slot 1, first execute cycle
    output instr_code_t          o_code_1,
    output logic [REG_IDX_W-1:0] o_rs_1,
    output logic [REG_IDX_W-1:0] o_rt_1,
    output logic [REG_IDX_W-1:0] o_rd_1,
    output logic [REG_IDX_W-1:0] o_shamt_1,
    output logic [WORD_W-1:0]    o_imm_1,
    output logic [TARGET_W-1:0]  o_target_1,

    // slot 2 and control
    output instr_code_t          o_code_2,
    output logic [REG_IDX_W-1:0] o_dest_2,
    output logic                 o_reg_write,
    output logic                 o_stall
);

    decode_if slot1_if ();
    decode_if slot2_if ();

    slot_control u_slots (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .i_mem_wait    (i_mem_wait),
        .i_code_1      (slot1_if.code),
        .o_word_1      (slot1_if.word),
        .o_word_2      (slot2_if.word),
        .o_stall       (o_stall)
    );

    // source indices straight from the word
    assign slot1_if.rs = slot1_if.word.r.rs;
    assign slot1_if.rt = slot1_if.word.r.rt;

    instr_classifier u_class_1 (
        .i_word (slot1_if.word),
        .o_code (slot1_if.code)
    );

    instr_classifier u_class_2 (
        .i_word (slot2_if.word),
        .o_code (slot2_if.code)
    );

    field_extractor u_fields_1 (.fields(slot1_if.producer));
    field_extractor u_fields_2 (.fields(slot2_if.producer));

    writeback_control u_wb (
        .slot        (slot2_if.consumer),
        .o_reg_write (o_reg_write)
    );

    assign o_code_1   = slot1_if.code;
    assign o_rs_1     = slot1_if.rs;
    assign o_rt_1     = slot1_if.rt;
    assign o_rd_1     = slot1_if.dest;  // resolved destination, rd for r-type
    assign o_shamt_1  = slot1_if.shamt;
    assign o_imm_1    = slot1_if.imm;
    assign o_target_1 = slot1_if.target;

    assign o_code_2 = slot2_if.code;
    assign o_dest_2 = slot2_if.dest;

endmodule

// File: test/tb_instr_decoder.sv
module tb_instr_decoder
    import mips_isa_pkg::*;
    import decode_pkg::*;
();

    localparam int N_FIELD    = 40;
    localparam int RUN_CYCLES = 3 + 56 + N_FIELD + 6 + 12 + 8 + 10 + 2;
    localparam int MAX_CYCLES = RUN_CYCLES + 50;

    // operation table: r-type functs, then regimm rt selectors, then opcodes
    localparam logic [5:0] OP_KEY [52] = '{
        FN_ADD, FN_ADDU, FN_AND, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO, FN_MTHI,
        FN_MTLO, FN_MULT, FN_MULTU, FN_OR, FN_SLL, FN_SLLV, FN_SLT, FN_SLTU,
        FN_SRA, FN_SRAV, FN_SRL, FN_SRLV, FN_SUBU, FN_XOR, FN_JALR, FN_JR,
        RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL,
        OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU,
        OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH,
        OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_SB, OP_SH, OP_SW
    };
    localparam instr_code_t OP_CODE [52] = '{
        ADD, ADDU, AND, DIV, DIVU, MFHI, MFLO, MTHI,
        MTLO, MULT, MULTU, OR, SLL, SLLV, SLT, SLTU,
        SRA, SRAV, SRL, SRLV, SUBU, XOR, JALR, JR,
        BLTZ, BGEZ, BLTZAL, BGEZAL,
        J, JAL, BEQ, BNE, BLEZ, BGTZ, ADDI, ADDIU,
        SLTI, SLTIU, ANDI, ORI, XORI, LUI, LB, LH,
        LWL, LW, LBU, LHU, LWR, SB, SH, SW
    };

    logic clk;
    logic i_reset;
    logic [31:0] i_instr;
    logic i_instr_valid;
    logic i_mem_wait;
    instr_code_t o_code_1;
    instr_code_t o_code_2;
    logic [4:0] o_rs_1;
    logic [4:0] o_rt_1;
    logic [4:0] o_rd_1;
    logic [4:0] o_shamt_1;
    logic [31:0] o_imm_1;
    logic [25:0] o_target_1;
    logic [4:0] o_dest_2;
    logic o_reg_write;
    logic o_stall;

    // expected slot contents and the inputs waiting for the next edge
    logic [31:0] m_word1;
    logic [31:0] m_word2;
    instr_code_t m_code1;
    instr_code_t m_code2;
    logic [31:0] pend_word;
    instr_code_t pend_code;
    logic pend_valid;
    logic pend_wait;

    integer seed;
    int checks = 0;
    int mismatches = 0;
    int cycles = 0;

    instr_decoder UUT (
        .clk(clk), .i_reset(i_reset), .i_instr(i_instr),
        .i_instr_valid(i_instr_valid), .i_mem_wait(i_mem_wait),
        .o_code_1(o_code_1), .o_rs_1(o_rs_1), .o_rt_1(o_rt_1), .o_rd_1(o_rd_1),
        .o_shamt_1(o_shamt_1), .o_imm_1(o_imm_1), .o_target_1(o_target_1),
        .o_code_2(o_code_2), .o_dest_2(o_dest_2), .o_reg_write(o_reg_write),
        .o_stall(o_stall)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic is_mem_op(input instr_code_t c);
        return c inside {LB, LBU, LH, LHU, LW, LWL, LWR, SB, SH, SW};
    endfunction

    function automatic logic writes_reg(input logic [31:0] w, input instr_code_t c);
        logic r_writer;
        r_writer = (w[31:26] == OP_SPECIAL) && (c != INVALID)
            && !(c inside {MTHI, MTLO, JR, MULT, MULTU, DIV, DIVU});
        return r_writer || (c inside {ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
            LB, LBU, LH, LHU, LW, LWL, LWR, JAL, BGEZAL, BLTZAL});
    endfunction

    task automatic expect_fields(input logic [31:0] w, input instr_code_t c,
                                 output logic [4:0] dest, output logic [4:0] shamt,
                                 output logic [31:0] imm, output logic [25:0] target);
        dest = '0;
        shamt = '0;
        imm = '0;
        target = '0;
        if (w[31:26] == OP_SPECIAL) begin
            dest = w[15:11];
            shamt = w[10:6];
        end else if (w[31:26] == OP_J || w[31:26] == OP_JAL) begin
            target = w[25:0];
            dest = (w[31:26] == OP_JAL) ? 5'd31 : 5'd0;
        end else begin
            dest = (c == BGEZAL || c == BLTZAL) ? 5'd31 : w[20:16];
            if (c inside {ANDI, ORI, XORI}) begin
                imm = {16'h0000, w[15:0]};
            end else if (c == LUI) begin
                imm = {w[15:0], 16'h0000};
            end else begin
                imm = {{16{w[15]}}, w[15:0]};      // sign extension
            end
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        logic [4:0] dest1, shamt1, dest2, shamt2;
        logic [31:0] imm1, imm2;
        logic [25:0] target1, target2;
        expect_fields(m_word1, m_code1, dest1, shamt1, imm1, target1);
        expect_fields(m_word2, m_code2, dest2, shamt2, imm2, target2);
        compare("o_code_1", o_code_1, m_code1);
        compare("o_rs_1", o_rs_1, m_word1[25:21]);
        compare("o_rt_1", o_rt_1, m_word1[20:16]);
        compare("o_rd_1", o_rd_1, dest1);
        compare("o_shamt_1", o_shamt_1, shamt1);
        compare("o_imm_1", o_imm_1, imm1);
        compare("o_target_1", o_target_1, target1);
        compare("o_code_2", o_code_2, m_code2);
        compare("o_dest_2", o_dest_2, dest2);
        compare("o_reg_write", o_reg_write, writes_reg(m_word2, m_code2) && (dest2 != 0));
        compare("o_stall", o_stall, pend_wait && is_mem_op(m_code1));
    endtask

    // one clock: step the model over the edge, present new inputs, check mid-cycle
    task automatic advance(input logic [31:0] w, input instr_code_t c,
                           input logic valid, input logic mem_wait);
        logic stalled;
        @(posedge clk);
        stalled = pend_wait && is_mem_op(m_code1);
        if (stalled) begin
            m_word2 = BUBBLE_WORD;
            m_code2 = SLL;                         // all-zero word is sll r0, r0, 0
        end else begin
            m_word2 = m_word1;
            m_code2 = m_code1;
            m_word1 = valid_word(pend_valid, pend_word);
            m_code1 = pend_valid ? pend_code : SLL;
        end
        i_instr <= w;
        i_instr_valid <= valid;
        i_mem_wait <= mem_wait;
        pend_word = w;
        pend_code = c;
        pend_valid = valid;
        pend_wait = mem_wait;
        @(negedge clk);
        check_outputs();
    endtask

    function automatic logic [31:0] valid_word(input logic v, input logic [31:0] w);
        return v ? w : BUBBLE_WORD;
    endfunction

    // table entry k with its free fields filled from the random stream
    task automatic send_op(input int k, input logic mem_wait);
        logic [31:0] base, mask, r;
        r = $random(seed);
        if (k < 24) begin
            base = {OP_SPECIAL, 20'h00000, OP_KEY[k]};
            mask = 32'h03ff_ffc0;
        end else if (k < 28) begin
            base = {OP_REGIMM, 5'd0, OP_KEY[k][4:0], 16'h0000};
            mask = 32'h03e0_ffff;              // rs and offset only
        end else begin
            base = {OP_KEY[k], 26'h0000000};
            mask = 32'h03ff_ffff;
        end
        advance(base | (r & mask), OP_CODE[k], 1'b1, mem_wait);
    endtask

    task automatic test_classification();
        for (int k = 0; k < 52; k++) begin
            send_op(k, 1'b0);
        end
        advance({6'b111111, 26'h0a5a5a5}, INVALID, 1'b1, 1'b0);
        advance({OP_SPECIAL, 20'h12345, 6'b000001}, INVALID, 1'b1, 1'b0);
        advance({OP_REGIMM, 5'd3, 5'b00010, 16'h0040}, INVALID, 1'b1, 1'b0);
        advance(32'h0, SLL, 1'b0, 1'b0);
    endtask

    task automatic test_fields();
        int k;
        repeat (N_FIELD) begin
            k = $unsigned($random(seed)) % 52;
            send_op(k, 1'b0);
        end
        advance({OP_ADDI, 5'd3, 5'd4, 16'h8001}, ADDI, 1'b1, 1'b0);
        advance({OP_ORI, 5'd5, 5'd6, 16'h8001}, ORI, 1'b1, 1'b0);
        advance({OP_XORI, 5'd7, 5'd8, 16'hffff}, XORI, 1'b1, 1'b0);
        advance({OP_ANDI, 5'd9, 5'd10, 16'hf00f}, ANDI, 1'b1, 1'b0);
        advance({OP_LUI, 5'd0, 5'd11, 16'h1234}, LUI, 1'b1, 1'b0);
        advance({OP_SLTI, 5'd12, 5'd13, 16'h7fff}, SLTI, 1'b1, 1'b0);
    endtask

    task automatic test_pipeline();
        for (int i = 0; i < 8; i++) begin
            send_op((i * 7) % 52, 1'b0);
        end
        advance(32'hdeadbeef, INVALID, 1'b0, 1'b0);  // fetch gap, word ignored
        send_op(1, 1'b0);
        advance(32'hdeadbeef, INVALID, 1'b0, 1'b0);
        advance(32'h0, SLL, 1'b0, 1'b0);
    endtask

    task automatic test_writeback();
        advance({OP_JAL, 26'h0123456}, JAL, 1'b1, 1'b0);
        advance({OP_REGIMM, 5'd7, RT_BGEZAL, 16'hfff0}, BGEZAL, 1'b1, 1'b0);
        advance({OP_REGIMM, 5'd8, RT_BLTZAL, 16'h0010}, BLTZAL, 1'b1, 1'b0);
        advance({OP_SPECIAL, 5'd1, 5'd2, 5'd0, 5'd0, FN_ADDU}, ADDU, 1'b1, 1'b0);
        advance({OP_ADDI, 5'd1, 5'd0, 16'h0004}, ADDI, 1'b1, 1'b0);
        advance({OP_SW, 5'd2, 5'd9, 16'h0008}, SW, 1'b1, 1'b0);
        advance({OP_SPECIAL, 5'd3, 5'd4, 5'd0, 5'd0, FN_MULT}, MULT, 1'b1, 1'b0);
        advance(32'h0, SLL, 1'b0, 1'b0);
    endtask

    task automatic test_stall();
        logic [31:0] held;
        held = {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU};
        advance({OP_LW, 5'd4, 5'd5, 16'h0010}, LW, 1'b1, 1'b0);
        advance(held, ADDU, 1'b1, 1'b1);           // load in slot 1, memory busy
        advance(held, ADDU, 1'b1, 1'b1);
        advance(held, ADDU, 1'b1, 1'b0);           // wait drops here
        advance({OP_ORI, 5'd6, 5'd7, 16'h00ff}, ORI, 1'b1, 1'b1);
        advance({OP_LUI, 5'd0, 5'd8, 16'habcd}, LUI, 1'b1, 1'b1);
        advance(32'h0, SLL, 1'b0, 1'b1);           // lui is no memory access
        advance({OP_SB, 5'd9, 5'd10, 16'h0002}, SB, 1'b1, 1'b0);
        advance(32'h0, SLL, 1'b0, 1'b1);
        advance(32'h0, SLL, 1'b0, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        i_reset = 1'b1;
        i_instr = '0;
        i_instr_valid = 1'b0;
        i_mem_wait = 1'b0;
        seed = 90000;
        m_word1 = BUBBLE_WORD;
        m_word2 = BUBBLE_WORD;
        m_code1 = SLL;
        m_code2 = SLL;
        pend_word = '0;
        pend_code = SLL;
        pend_valid = 1'b0;
        pend_wait = 1'b0;
        repeat (3) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        if (o_reg_write !== 1'b0 || o_stall !== 1'b0) begin
            mismatches++;
            $display("mismatch at %0t: o_reg_write or o_stall high after reset", $time);
        end
        test_classification();
        test_fields();
        test_pipeline();
        test_writeback();
        test_stall();
        advance(32'h0, SLL, 1'b0, 1'b0);
        $display("checks run: %0d, mismatches: %0d", checks, mismatches);
        if (mismatches == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/mips_isa_pkg.sv
rtl/decode_pkg.sv
rtl/decode_if.sv
rtl/instr_classifier.sv
rtl/field_extractor.sv
rtl/slot_control.sv
rtl/writeback_control.sv
rtl/instr_decoder.sv
test/tb_instr_decoder.sv
